//--- sim.f
hdl/dccm_pkg.sv
hdl/dccm_req_fifo.sv
hdl/dccm_credit_counter.sv
hdl/dccm_error_inject.sv
hdl/dccm_bank_array.sv
hdl/dccm_export_top.sv
tests/tb_clock_gen.sv
tests/tb_dccm_checker.sv
tests/tb_dccm_export.sv

//--- run_sim.sh
#!/bin/sh
# build and run the DCCM testbench with Verilator; result decided from sim.log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f sim.f --top-module tb_dccm_export \
    -Mdir obj_dir -o tb_sim > build.log 2>&1 || { echo "build failed, see build.log"; exit 1; }

./obj_dir/tb_sim > sim.log 2>&1

grep -qx "TB PASSED" sim.log && echo "simulation passed" || { echo "simulation failed, see sim.log"; exit 1; }

//--- tests/tb_dccm_export.sv
/*
 * Testbench top for the banked DCCM.
 * Builds random request lists per test, sends them against request credits,
 * returns response credits after random delays and runs the watchdog.
 * Checking is done in tb_dccm_checker.
 */
`timescale 1ns/1ps

module tb_dccm_export import dccm_pkg::*; ();

    localparam int n_clean  = 24;     // writes, then as many reads
    localparam int n_inject = 90;     // write/read pairs per inject test
    localparam int n_burst  = 30;
    localparam int n_bp     = 40;
    localparam int total_reqs = 2 * n_clean + 4 * n_inject + n_burst + n_bp;
    localparam int clk_period = 8;

    logic         clk;
    logic         rst;
    inject_mode_t inject_mode;
    logic         req_valid;
    dccm_req_t    req;
    logic         req_credit;
    logic         rsp_valid;
    dccm_rsp_t    rsp;
    logic         rsp_credit;

    int           test_id;
    logic         test_end;
    logic         idle;
    int           pass_total;
    int           fail_total;

    integer       seed;
    dccm_req_t    req_q [$];      // requests waiting to go out
    dccm_addr_t   wr_addrs [$];   // addresses holding known data
    int           credits;        // sender side request credits
    logic         burst;          // send every cycle a credit allows
    int           max_delay;      // consumer credit return delay
    int           owed;           // responses not yet credited back
    int           delay;

    tb_clock_gen u_clock_gen (
        .clk (clk),
        .rst (rst)
    );

    dccm_export_top DUT (
        .cptra_ss_mcu0_el2_mem_export (clk),
        .rst                          (rst),
        .inject_mode                  (inject_mode),
        .req_valid                    (req_valid),
        .req                          (req),
        .req_credit                   (req_credit),
        .rsp_valid                    (rsp_valid),
        .rsp                          (rsp),
        .rsp_credit                   (rsp_credit)
    );

    tb_dccm_checker u_checker (
        .clk         (clk),
        .rst         (rst),
        .inject_mode (inject_mode),
        .req_valid   (req_valid),
        .req         (req),
        .req_credit  (req_credit),
        .rsp_valid   (rsp_valid),
        .rsp         (rsp),
        .rsp_credit  (rsp_credit),
        .test_id     (test_id),
        .test_end    (test_end),
        .idle        (idle),
        .pass_total  (pass_total),
        .fail_total  (fail_total)
    );

    //////////////////////////////////////////////////////////////////////
    // request building
    //////////////////////////////////////////////////////////////////////
    function automatic dccm_req_t make_write(dccm_addr_t addr);
        dccm_req_t r;
        r.wr   = 1'b1;
        r.addr = addr;
        r.data = dccm_data_t'($random(seed));
        r.ecc  = dccm_ecc_t'($random(seed));
        return r;
    endfunction

    function automatic dccm_req_t make_read(dccm_addr_t addr);
        dccm_req_t r;
        r      = '0;
        r.addr = addr;
        return r;
    endfunction

    function automatic dccm_addr_t pick_written();
        int k;
        k = $random(seed) % wr_addrs.size();
        if (k < 0) begin
            k = -k;
        end
        return wr_addrs[k];
    endfunction

    task automatic queue_write();
        dccm_addr_t a;
        a = dccm_addr_t'($random(seed));
        wr_addrs.push_back(a);
        req_q.push_back(make_write(a));
    endtask

    // random mix with reads only where data is known
    task automatic queue_mixed(int n);
        for (int i = 0; i < n; i++) begin
            if (wr_addrs.size() == 0 || ($random(seed) & 1) != 0) begin
                queue_write();
            end else begin
                req_q.push_back(make_read(pick_written()));
            end
        end
    endtask

    task automatic wait_idle();
        while (req_q.size() != 0) @(posedge clk);
        repeat (3) @(posedge clk);
        while (!idle) @(posedge clk);
    endtask

    task automatic finish_test(int id);
        test_id  <= id;
        test_end <= 1'b1;
        @(posedge clk);
        test_end <= 1'b0;
        @(posedge clk);
    endtask

    //////////////////////////////////////////////////////////////////////
    // sender and consumer
    //////////////////////////////////////////////////////////////////////
    always @(posedge clk) begin
        if (rst) begin
            credits = req_credits;
            req_valid <= 1'b0;
        end else begin
            credits = credits + (req_credit ? 1 : 0);    // pulse from the cycle just ended
            if (req_q.size() != 0 && credits > 0 && (burst || ($random(seed) & 3) != 0)) begin
                req       <= req_q.pop_front();
                req_valid <= 1'b1;
                credits   = credits - 1;
            end else begin
                req_valid <= 1'b0;
            end
        end
    end

    always @(posedge clk) begin
        if (rst) begin
            owed  = 0;
            delay = 0;
            rsp_credit <= 1'b0;
        end else begin
            if (rsp_valid) begin
                owed = owed + 1;
            end
            if (owed > 0 && delay == 0) begin
                rsp_credit <= 1'b1;
                owed  = owed - 1;
                delay = $random(seed) % (max_delay + 1);
                if (delay < 0) begin
                    delay = -delay;
                end
            end else begin
                rsp_credit <= 1'b0;
                if (delay > 0) begin
                    delay = delay - 1;
                end
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // test sequence
    //////////////////////////////////////////////////////////////////////
    initial begin
        seed        = 49008;
        inject_mode = inject_off;
        req_valid   = 1'b0;
        req         = '0;
        rsp_credit  = 1'b0;
        test_id     = 0;
        test_end    = 1'b0;
        burst       = 1'b0;
        max_delay   = 5;
        credits     = req_credits;

        while (rst) @(posedge clk);
        @(posedge clk);
        finish_test(0);    // reset_quiet

        test_id <= 1;
        for (int i = 0; i < n_clean; i++) begin
            queue_write();
        end
        for (int i = 0; i < n_clean; i++) begin
            req_q.push_back(make_read(wr_addrs[wr_addrs.size() - n_clean + i]));
        end
        wait_idle();
        finish_test(1);

        test_id     <= 2;
        inject_mode <= inject_single;
        for (int i = 0; i < n_inject; i++) begin
            queue_write();
            req_q.push_back(make_read(wr_addrs[wr_addrs.size() - 1]));
        end
        wait_idle();
        finish_test(2);

        test_id     <= 3;
        inject_mode <= inject_double;    // long enough to cross the 38 to 0 wrap
        for (int i = 0; i < n_inject; i++) begin
            queue_write();
            req_q.push_back(make_read(wr_addrs[wr_addrs.size() - 1]));
        end
        wait_idle();
        finish_test(3);

        test_id     <= 4;
        inject_mode <= inject_off;
        burst       = 1'b1;
        queue_mixed(n_burst);
        wait_idle();
        burst = 1'b0;
        finish_test(4);

        test_id   <= 5;
        max_delay = 30;    // consumer sits on credits
        queue_mixed(n_bp);
        wait_idle();
        max_delay = 5;
        finish_test(5);

        @(posedge clk);
        $display("tests passed %0d, failed %0d", pass_total, fail_total);
        if (fail_total == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

    // watchdog
    initial begin
        #(total_reqs * 20 * clk_period);
        $display("watchdog timeout, requests or responses stopped moving");
        $display("TB FAILED");
        $finish;
    end

endmodule

//--- tests/tb_dccm_checker.sv
/*
 * Checker for the DCCM testbench.
 * Watches the DUT ports, models injection and storage from accepted
 * requests, checks responses in order and the credit rules,
 * and prints one result line per test.
 */
`timescale 1ns/1ps

module tb_dccm_checker import dccm_pkg::*; (
    input  logic         clk,
    input  logic         rst,
    input  inject_mode_t inject_mode,
    input  logic         req_valid,
    input  dccm_req_t    req,
    input  logic         req_credit,
    input  logic         rsp_valid,
    input  dccm_rsp_t    rsp,
    input  logic         rsp_credit,
    input  int           test_id,
    input  logic         test_end,
    output logic         idle,
    output int           pass_total,
    output int           fail_total
);

    dccm_word_t model_mem [num_banks * bank_depth];
    dccm_word_t exp_q [$];
    logic       parity;
    int         pos;
    int         outstanding;
    int         rsp_seen;
    int         credits_back;
    int         sent;
    int         pulses;
    int         errs;
    logic       rst_d;

    function automatic string test_name(int id);
        case (id)
            0:       return "reset_quiet";
            1:       return "clean_rw";
            2:       return "single_inject";
            3:       return "double_inject";
            4:       return "req_credits";
            default: return "rsp_backpressure";
        endcase
    endfunction

    function automatic int next_pos(int p);
        return (p == word_width - 1) ? 0 : p + 1;
    endfunction

    //////////////////////////////////////////////////////////////////////
    // model and checks
    //////////////////////////////////////////////////////////////////////
    initial begin
        pass_total = 0;
        fail_total = 0;
        errs       = 0;
        idle       = 1'b0;
    end

    always @(posedge clk) begin
        dccm_word_t w;
        dccm_word_t got;
        rst_d <= rst;
        if (rst || rst_d) begin
            if (rsp_valid || req_credit) begin
                $display("%s: response or request credit seen during reset",
                         test_name(test_id));
                errs = errs + 1;
            end
        end
        if (rst) begin
            parity = 1'b0;
            pos = 0;
            outstanding = 0;
            rsp_seen = 0;
            credits_back = 0;
            sent = 0;
            pulses = 0;
            exp_q.delete();
        end else begin
            // a dispatch needs a request accepted in an earlier cycle
            if (req_credit && outstanding == 0) begin
                $display("%s: request credit returned with no request queued",
                         test_name(test_id));
                errs = errs + 1;
            end
            if (req_valid) begin
                if (outstanding >= req_credits) begin
                    $display("%s: request sent while 4 requests outstanding",
                             test_name(test_id));
                    errs = errs + 1;
                end
                outstanding = outstanding + 1;
                sent = sent + 1;
                if (req.wr) begin
                    w = {req.ecc, req.data};
                    if (inject_mode != inject_off && parity) begin
                        w[pos] = ~w[pos];
                        if (inject_mode == inject_double) begin
                            w[next_pos(pos)] = ~w[next_pos(pos)];
                        end
                        pos = next_pos(pos);
                    end
                    parity = ~parity;    // every write, any mode
                    model_mem[req.addr] = w;
                end else begin
                    exp_q.push_back(model_mem[req.addr]);
                end
            end
            if (req_credit) begin
                outstanding = outstanding - 1;
                pulses = pulses + 1;
            end
            if (rsp_credit) begin
                credits_back = credits_back + 1;
            end
            if (rsp_valid) begin
                rsp_seen = rsp_seen + 1;
                got = {rsp.ecc, rsp.data};
                if (rsp_seen > rsp_credits + credits_back) begin
                    $display("%s: response sent without a response credit",
                             test_name(test_id));
                    errs = errs + 1;
                end
                if (exp_q.size() == 0) begin
                    $display("%s: response with no read pending", test_name(test_id));
                    errs = errs + 1;
                end else begin
                    w = exp_q.pop_front();
                    if (got !== w) begin
                        $display("[ERROR] %s expected %h actual %h",
                                 test_name(test_id), w, got);
                        errs = errs + 1;
                    end
                end
            end
        end
        idle <= (exp_q.size() == 0) && (outstanding == 0);

        // per-test result
        if (test_end) begin
            if (pulses != sent) begin
                $display("[ERROR] %s expected %0d actual %0d", test_name(test_id), sent, pulses);
                errs = errs + 1;
            end
            if (errs == 0) begin
                $display("PASS %s", test_name(test_id));
                pass_total = pass_total + 1;
            end else begin
                $display("FAIL %s with %0d errors", test_name(test_id), errs);
                fail_total = fail_total + 1;
            end
            errs   = 0;
            sent   = 0;
            pulses = 0;
        end
    end

endmodule

//--- tests/tb_clock_gen.sv
/*
 * Clock and reset source for the DCCM testbench.
 * 8 ns clock, synchronous active-high reset held for 3 rising edges.
 */
`timescale 1ns/1ps

module tb_clock_gen (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;    // 8 ns period
    end

    initial begin
        rst = 1'b1;
        repeat (3) @(posedge clk);
        rst <= 1'b0;
    end

endmodule

//--- hdl/dccm_export_top.sv
/*
 * Top of the banked DCCM with credit-based request and response channels.
 * Ties together the request queue, response credit counter,
 * write-error injector and bank array.
 */
`timescale 1ns/1ps

module dccm_export_top import dccm_pkg::*; (
    input  logic         cptra_ss_mcu0_el2_mem_export,
    input  logic         rst,
    input  inject_mode_t inject_mode,
    // request channel
    input  logic         req_valid,
    input  dccm_req_t    req,
    output logic         req_credit,
    // response channel
    output logic         rsp_valid,
    output dccm_rsp_t    rsp,
    input  logic         rsp_credit
);

    logic       disp_valid;
    dccm_req_t  disp_req;
    logic       rd_issue;
    logic       credit_avail;
    dccm_word_t wr_word;

    //////////////////////////////////////////////////////////////////////
    // request side
    //////////////////////////////////////////////////////////////////////
    dccm_req_fifo u_req_fifo (
        .cptra_ss_mcu0_el2_mem_export (cptra_ss_mcu0_el2_mem_export),
        .rst                          (rst),
        .req_valid                    (req_valid),
        .req                          (req),
        .credit_avail                 (credit_avail),
        .disp_valid                   (disp_valid),
        .disp_req                     (disp_req),
        .rd_issue                     (rd_issue),
        .req_credit                   (req_credit)
    );

    dccm_credit_counter u_credit_counter (
        .cptra_ss_mcu0_el2_mem_export (cptra_ss_mcu0_el2_mem_export),
        .rst                          (rst),
        .rd_issue                     (rd_issue),
        .rsp_credit                   (rsp_credit),
        .credit_avail                 (credit_avail)
    );

    //////////////////////////////////////////////////////////////////////
    // storage side
    //////////////////////////////////////////////////////////////////////
    dccm_error_inject u_error_inject (
        .cptra_ss_mcu0_el2_mem_export (cptra_ss_mcu0_el2_mem_export),
        .rst                          (rst),
        .inject_mode                  (inject_mode),
        .disp_valid                   (disp_valid),
        .disp_req                     (disp_req),
        .wr_word                      (wr_word)
    );

    dccm_bank_array u_bank_array (
        .cptra_ss_mcu0_el2_mem_export (cptra_ss_mcu0_el2_mem_export),
        .rst                          (rst),
        .disp_valid                   (disp_valid),
        .disp_req                     (disp_req),
        .wr_word                      (wr_word),
        .rsp_valid                    (rsp_valid),
        .rsp                          (rsp)
    );

endmodule

//--- hdl/dccm_bank_array.sv
/*
 * Banked DCCM storage, num_banks banks of bank_depth 39-bit words.
 * Address low bits pick the bank, high bits the word in that bank.
 * Writes store the injector's word; reads come back one cycle later
 * split into data and check fields with rsp_valid.
 */
`timescale 1ns/1ps

module dccm_bank_array import dccm_pkg::*; (
    input  logic       cptra_ss_mcu0_el2_mem_export,
    input  logic       rst,
    input  logic       disp_valid,
    input  dccm_req_t  disp_req,
    input  dccm_word_t wr_word,
    output logic       rsp_valid,
    output dccm_rsp_t  rsp
);

    bank_sel_t                   bank_sel;
    bank_index_t                 bank_idx;
    bank_sel_t                   rd_bank;    // bank of the read in flight
    logic                        rd_en;
    logic                        wr_en;
    dccm_word_t [num_banks-1:0]  bank_dout;

    //////////////////////////////////////////////////////////////////////
    // address decode
    //////////////////////////////////////////////////////////////////////
    assign bank_sel = disp_req.addr[$bits(bank_sel_t)-1:0];
    assign bank_idx = disp_req.addr[$bits(dccm_addr_t)-1:$bits(bank_sel_t)];

    assign rd_en = disp_valid && !disp_req.wr;
    assign wr_en = disp_valid && disp_req.wr;

    //////////////////////////////////////////////////////////////////////
    // banks
    //////////////////////////////////////////////////////////////////////
    for (genvar i = 0; i < num_banks; i++) begin : g_bank
        dccm_word_t mem [bank_depth];
        dccm_word_t dout;
        logic       wren_bank;
        logic       rden_bank;

        assign wren_bank = wr_en && (bank_sel == bank_sel_t'(i));
        assign rden_bank = rd_en && (bank_sel == bank_sel_t'(i));

        always_ff @(posedge cptra_ss_mcu0_el2_mem_export) begin
            if (wren_bank) begin
                mem[bank_idx] <= wr_word;
            end
            if (rden_bank) begin
                dout <= mem[bank_idx];    // registered read
            end
        end

        assign bank_dout[i] = dout;
    end

    //////////////////////////////////////////////////////////////////////
    // response
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge cptra_ss_mcu0_el2_mem_export) begin
        if (rst) begin
            rsp_valid <= 1'b0;
        end else begin
            rsp_valid <= rd_en;
        end
    end

    always_ff @(posedge cptra_ss_mcu0_el2_mem_export) begin
        if (rd_en) begin
            rd_bank <= bank_sel;
        end
    end

    // split stored word back into its fields
    assign rsp.data = bank_dout[rd_bank][data_width-1:0];
    assign rsp.ecc  = bank_dout[rd_bank][word_width-1:data_width];

endmodule

//--- hdl/dccm_error_inject.sv
/*
 * Deterministic write-error injector for the DCCM.
 * Packs {ecc, data} into the stored word and, while injection is on,
 * corrupts every second dispatched write. The flipped bit walks 0..38.
 */
`timescale 1ns/1ps

module dccm_error_inject import dccm_pkg::*; (
    input  logic         cptra_ss_mcu0_el2_mem_export,
    input  logic         rst,
    input  inject_mode_t inject_mode,
    input  logic         disp_valid,
    input  dccm_req_t    disp_req,
    output dccm_word_t   wr_word
);

    logic       wr_parity;    // high on every second write since reset
    flip_pos_t  flip_pos;
    flip_pos_t  next_pos;
    logic       is_wr;
    logic       corrupt;
    dccm_word_t flip_mask;

    assign is_wr = disp_valid && disp_req.wr;

    // next bit up, wrapping from the top check bit to data bit 0
    assign next_pos = (flip_pos == flip_pos_t'(word_width - 1)) ? '0
                                                                : flip_pos + flip_pos_t'(1);

    //////////////////////////////////////////////////////////////////////
    // mask build
    //////////////////////////////////////////////////////////////////////
    always_comb begin
        flip_mask = '0;
        if (is_wr && wr_parity) begin
            case (inject_mode)
                inject_single: begin
                    flip_mask[flip_pos] = 1'b1;
                end
                inject_double: begin
                    flip_mask[flip_pos] = 1'b1;
                    flip_mask[next_pos] = 1'b1;    // adjacent pair
                end
                default: begin
                    flip_mask = '0;    // off
                end
            endcase
        end
    end

    assign corrupt = (flip_mask != '0);
    assign wr_word = {disp_req.ecc, disp_req.data} ^ flip_mask;

    //////////////////////////////////////////////////////////////////////
    // write parity and flip position
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge cptra_ss_mcu0_el2_mem_export) begin
        if (rst) begin
            wr_parity <= 1'b0;
            flip_pos  <= '0;
        end else if (is_wr) begin
            wr_parity <= ~wr_parity;    // counts writes in any mode
            if (corrupt) begin
                flip_pos <= next_pos;
            end
        end
    end

    a_flip_pos_range: assert property (
        @(posedge cptra_ss_mcu0_el2_mem_export) disable iff (rst)
        flip_pos < flip_pos_t'(word_width)
    ) else $error("flip position outside the stored word");

endmodule

//--- hdl/dccm_credit_counter.sv
/*
 * Response credit count for the DCCM.
 * Starts at rsp_credits, goes down per issued read, up per returned credit.
 * credit_avail tells the request queue that a read may be dispatched.
 */
`timescale 1ns/1ps

module dccm_credit_counter import dccm_pkg::*; (
    input  logic cptra_ss_mcu0_el2_mem_export,
    input  logic rst,
    input  logic rd_issue,
    input  logic rsp_credit,
    output logic credit_avail
);

    rsp_cnt_t credit_cnt;

    assign credit_avail = (credit_cnt != '0);

    always_ff @(posedge cptra_ss_mcu0_el2_mem_export) begin
        if (rst) begin
            credit_cnt <= rsp_cnt_t'(rsp_credits);
        end else if (rd_issue && !rsp_credit) begin
            credit_cnt <= credit_cnt - rsp_cnt_t'(1);
        end else if (rsp_credit && !rd_issue) begin
            credit_cnt <= credit_cnt + rsp_cnt_t'(1);
        end
        // both at once leaves the count alone
    end

    // queue only issues reads against a held credit
    a_no_underflow: assert property (
        @(posedge cptra_ss_mcu0_el2_mem_export) disable iff (rst)
        rd_issue |-> credit_cnt != '0
    ) else $error("read issued with no response credit");

    // consumer returns no more than it was given
    a_no_overflow: assert property (
        @(posedge cptra_ss_mcu0_el2_mem_export) disable iff (rst)
        (rsp_credit && !rd_issue) |-> credit_cnt < rsp_cnt_t'(rsp_credits)
    ) else $error("response credit count above rsp_credits");

endmodule

//--- hdl/dccm_req_fifo.sv
/*
 * In-order request queue in front of the DCCM banks.
 * Holds up to req_credits requests and hands the head out combinationally.
 * Writes leave at once; reads wait for a response credit.
 * One req_credit pulse goes back to the sender per dispatched request.
 */
`timescale 1ns/1ps

module dccm_req_fifo import dccm_pkg::*; (
    input  logic      cptra_ss_mcu0_el2_mem_export,
    input  logic      rst,
    input  logic      req_valid,
    input  dccm_req_t req,
    input  logic      credit_avail,
    output logic      disp_valid,
    output dccm_req_t disp_req,
    output logic      rd_issue,
    output logic      req_credit
);

    dccm_req_t q_mem [req_credits];
    req_ptr_t  wr_ptr;
    req_ptr_t  rd_ptr;
    req_cnt_t  count;
    logic      empty;
    logic      full;
    logic      push;
    logic      pop;

    assign empty = (count == '0);
    assign full  = (count == req_cnt_t'(req_credits));
    assign push  = req_valid && !full;    // sender should never hit full

    //////////////////////////////////////////////////////////////////////
    // head dispatch
    //////////////////////////////////////////////////////////////////////
    assign disp_req   = q_mem[rd_ptr];
    // a read head stalls everything behind it until a credit shows up
    assign disp_valid = !empty && (disp_req.wr || credit_avail);
    assign pop        = disp_valid;
    assign rd_issue   = disp_valid && !disp_req.wr;
    assign req_credit = pop;              // one credit back per dispatch

    //////////////////////////////////////////////////////////////////////
    // storage and pointers
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge cptra_ss_mcu0_el2_mem_export) begin
        if (push) begin
            q_mem[wr_ptr] <= req;
        end
    end

    always_ff @(posedge cptra_ss_mcu0_el2_mem_export) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == req_ptr_t'(req_credits - 1)) ? '0
                                                                 : wr_ptr + req_ptr_t'(1);
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == req_ptr_t'(req_credits - 1)) ? '0
                                                                 : rd_ptr + req_ptr_t'(1);
            end
            case ({push, pop})
                2'b10:   count <= count + req_cnt_t'(1);
                2'b01:   count <= count - req_cnt_t'(1);
                default: count <= count;    // idle, or push and pop together
            endcase
        end
    end

    // sender keeps to its credits, so the queue is never pushed when full
    a_no_push_when_full: assert property (
        @(posedge cptra_ss_mcu0_el2_mem_export) disable iff (rst)
        req_valid |-> !full
    ) else $error("request pushed into full queue");

endmodule

//--- hdl/dccm_pkg.sv
/*
 * Shared sizes, widths and types for the banked DCCM.
 * Every DCCM module and the testbench pull this in with a wildcard import.
 * A stored word is 39 bits, the 7-bit check field sitting above 32 data bits.
 */

package dccm_pkg;

    //////////////////////////////////////////////////////////////////////
    // sizes
    //////////////////////////////////////////////////////////////////////
    localparam int num_banks   = 8;
    localparam int bank_depth  = 64;      // words per bank
    localparam int data_width  = 32;
    localparam int ecc_width   = 7;
    localparam int word_width  = data_width + ecc_width;
    localparam int req_credits = 4;       // request queue depth
    localparam int rsp_credits = 2;       // response credits held after reset

    //////////////////////////////////////////////////////////////////////
    // plain vector types
    //////////////////////////////////////////////////////////////////////
    typedef logic [$clog2(num_banks)-1:0]  bank_sel_t;
    typedef logic [$clog2(bank_depth)-1:0] bank_index_t;

    // bank in the low bits, index above
    typedef logic [$bits(bank_index_t)+$bits(bank_sel_t)-1:0] dccm_addr_t;

    typedef logic [data_width-1:0] dccm_data_t;
    typedef logic [ecc_width-1:0]  dccm_ecc_t;
    typedef logic [word_width-1:0] dccm_word_t;    // {ecc, data}
    typedef logic [5:0]            flip_pos_t;     // 0 .. word_width-1

    // queue bookkeeping
    typedef logic [$clog2(req_credits)-1:0]   req_ptr_t;
    typedef logic [$clog2(req_credits+1)-1:0] req_cnt_t;
    typedef logic [$clog2(rsp_credits+1)-1:0] rsp_cnt_t;

    typedef enum logic [1:0] {
        inject_off    = 2'd0,
        inject_single = 2'd1,
        inject_double = 2'd2
    } inject_mode_t;

    //////////////////////////////////////////////////////////////////////
    // channel payloads
    //////////////////////////////////////////////////////////////////////
    typedef struct packed {
        logic       wr;      // 1 = write, 0 = read
        dccm_addr_t addr;
        dccm_data_t data;
        dccm_ecc_t  ecc;
    } dccm_req_t;

    typedef struct packed {
        dccm_data_t data;
        dccm_ecc_t  ecc;
    } dccm_rsp_t;

endpackage
